//--- wbPkg.sv
// widths, flag bit positions and packet structs of the writeback stage.
package wbPkg;

        // ============================================================
        // widths
        // ============================================================
        localparam int checkpoints       = 4;   // branch mask width.
        localparam int checkpointsLog    = 2;
        localparam int executionFlags    = 6;
        localparam int writebackFlags    = 4;   // low flags seen by the active list.
        localparam int sizePhysicalLog   = 7;
        localparam int sizeActiveListLog = 7;
        localparam int sizeData          = 32;
        localparam int sizeIssueQLog     = 5;
        localparam int sizeLsqLog        = 5;
        localparam int sizeCtiLog        = 4;
        localparam int sizePc            = 32;

        // ============================================================
        // execution flag bits
        // ============================================================
        localparam int flagMispredict  = 0;
        localparam int flagException   = 1;
        localparam int flagLdViolation = 2;
        localparam int flagBranch      = 3;
        localparam int flagDestValid   = 4;     // result has a destination, gates bypass.
        localparam int flagConditional = 5;

        // ============================================================
        // packets
        // ============================================================
        typedef struct packed {
                logic [checkpoints-1:0]         branchMask;
                logic [executionFlags-1:0]      flags;
                logic [sizePhysicalLog-1:0]     phyDest;
                logic [sizeActiveListLog-1:0]   alId;
                logic [sizeData-1:0]            data;
                logic [sizeIssueQLog-1:0]       iqEntry;
                logic [sizeLsqLog-1:0]          lsqId;
                logic [checkpointsLog-1:0]      smtId;
                logic [sizeCtiLog-1:0]          ctiIndex;
                logic [sizePc-1:0]              targetAddr;
                logic                           brDirection;
        } exePacket_t;

        typedef struct packed {
                logic [checkpoints-1:0]         branchMask;
                logic [executionFlags-1:0]      flags;
                logic [sizeData-1:0]            data;
                logic [sizePhysicalLog-1:0]     phyDest;
                logic [sizeActiveListLog-1:0]   alId;
                logic [sizeIssueQLog-1:0]       iqEntry;
        } lsuPacket_t;

        // control word written into the active list.
        typedef struct packed {
                logic [sizeActiveListLog-1:0]   alId;
                logic [writebackFlags-1:0]      flags;
        } ctrlFu_t;

        typedef struct packed {
                logic [sizePhysicalLog-1:0]     phyDest;
                logic [sizeData-1:0]            data;
                logic [checkpointsLog-1:0]      smtId;
        } bypassPacket_t;

        typedef struct packed {
                logic                           valid;
                logic [sizeActiveListLog-1:0]   alId;
        } ldViolation_t;

endpackage

//--- wbLaneIf.sv
// registered lane interface and the branch squash broadcast interface.
`timescale 1ns/1ps

// one registered result lane in common form.
interface wbLaneIf;
        logic                                   valid;
        logic [wbPkg::checkpoints-1:0]          branchMask;
        logic [wbPkg::executionFlags-1:0]       flags;
        logic [wbPkg::sizePhysicalLog-1:0]      phyDest;
        logic [wbPkg::sizeActiveListLog-1:0]    alId;
        logic [wbPkg::sizeData-1:0]             data;
        logic [wbPkg::checkpointsLog-1:0]       smtId;

        modport laneReg (
                output valid, branchMask, flags, phyDest, alId, data, smtId
        );

        modport laneFmt (
                input  valid, branchMask, flags, phyDest, alId, data, smtId
        );
endinterface

// mispredict event from the branch lane, seen by every lane.
interface squashIf;
        logic                                   squashValid;
        logic [wbPkg::checkpointsLog-1:0]       squashId;       // checkpoint to kill.

        modport resolver (
                output squashValid, squashId
        );

        modport listener (
                input  squashValid, squashId
        );
endinterface

//--- wbLaneReg.sv
// one-cycle input register for a single writeback result lane.
`timescale 1ns/1ps

module wbLaneReg (
        input  logic                                    clk,
        input  logic                                    reset,
        input  logic                                    valid_i,
        input  logic [wbPkg::checkpoints-1:0]           branchMask_i,
        input  logic [wbPkg::executionFlags-1:0]        flags_i,
        input  logic [wbPkg::sizePhysicalLog-1:0]       phyDest_i,
        input  logic [wbPkg::sizeActiveListLog-1:0]     alId_i,
        input  logic [wbPkg::sizeData-1:0]              data_i,
        input  logic [wbPkg::checkpointsLog-1:0]        smtId_i,
        wbLaneIf.laneReg                                lane
);

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        lane.valid <= 1'b0;
                end
                else
                begin
                        lane.valid <= valid_i;
                end
        end

        // fields hold while the lane is idle.
        always_ff @(posedge clk)
        begin
                if (valid_i)
                begin
                        lane.branchMask <= branchMask_i;
                        lane.flags      <= flags_i;
                        lane.phyDest    <= phyDest_i;
                        lane.alId       <= alId_i;
                        lane.data       <= data_i;
                        lane.smtId      <= smtId_i;
                end
        end

endmodule

//--- branchResolve.sv
// branch lane resolution: branch field register, control outputs, squash event.
`timescale 1ns/1ps

module branchResolve (
        input  logic                                    clk,
        input  logic                                    reset,
        input  logic                                    valid_i,
        wbLaneIf.laneFmt                                lane2,
        input  logic [wbPkg::sizeCtiLog-1:0]            ctiIndex_i,
        input  logic [wbPkg::sizePc-1:0]                targetAddr_i,
        input  logic                                    brDirection_i,
        squashIf.resolver                               squash,
        output logic                                    ctrlVerified_o,
        output logic                                    ctrlMispredict_o,
        output logic                                    ctrlConditional_o,
        output logic [wbPkg::checkpointsLog-1:0]        ctrlSMTid_o,
        output logic [wbPkg::sizePc-1:0]                ctrlTargetAddr_o,
        output logic                                    ctrlBrDirection_o,
        output logic [wbPkg::sizeCtiLog-1:0]            ctrlCtiQueueIndex_o,
        output logic [wbPkg::sizePc-1:0]                computedAddr_o
);

        logic [wbPkg::sizeCtiLog-1:0]   ctiIndexReg;
        logic [wbPkg::sizePc-1:0]       targetAddrReg;
        logic                           brDirectionReg;
        logic                           mispredict;

        // ============================================================
        // branch fields, same load rule as the lane register
        // ============================================================
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        ctiIndexReg    <= '0;
                        targetAddrReg  <= '0;
                        brDirectionReg <= 1'b0;
                end
                else if (valid_i)
                begin
                        ctiIndexReg    <= ctiIndex_i;
                        targetAddrReg  <= targetAddr_i;
                        brDirectionReg <= brDirection_i;
                end
        end

        assign mispredict = lane2.flags[wbPkg::flagMispredict];

        assign ctrlVerified_o      = lane2.valid;
        assign ctrlMispredict_o    = mispredict;
        assign ctrlConditional_o   = lane2.flags[wbPkg::flagConditional];
        assign ctrlSMTid_o         = lane2.smtId;
        assign ctrlTargetAddr_o    = targetAddrReg;
        assign ctrlBrDirection_o   = brDirectionReg;
        assign ctrlCtiQueueIndex_o = ctiIndexReg;
        assign computedAddr_o      = targetAddrReg;     // only the branch lane computes one.

        // Kill everything younger than a verified wrong-path branch.
        assign squash.squashValid = lane2.valid & mispredict;
        assign squash.squashId    = lane2.smtId;

endmodule

//--- wbLaneFormat.sv
// per-lane writeback valid with squash, active list control word and bypass packet.
`timescale 1ns/1ps

module wbLaneFormat (
        wbLaneIf.laneFmt                lane,
        squashIf.listener               squash,
        output logic                    writebkValid_o,
        output wbPkg::ctrlFu_t          ctrlFu_o,
        output logic                    bypassValid_o,
        output wbPkg::bypassPacket_t    bypassPacket_o
);

        logic squashHit;

        // result depends on the mispredicted checkpoint.
        assign squashHit = squash.squashValid & lane.branchMask[squash.squashId];

        assign writebkValid_o = lane.valid & ~squashHit;
        assign bypassValid_o  = lane.valid & lane.flags[wbPkg::flagDestValid];  // not squashed.

        always_comb
        begin
                ctrlFu_o.alId          = lane.alId;
                ctrlFu_o.flags         = lane.flags[wbPkg::writebackFlags-1:0];
                bypassPacket_o.phyDest = lane.phyDest;
                bypassPacket_o.data    = lane.data;
                bypassPacket_o.smtId   = lane.smtId;
        end

endmodule

//--- writeBack.sv
// writeback stage top: three execution lanes, one load/store lane and branch resolution.
`timescale 1ns/1ps

module writeBack (
        input  logic                                    clk,
        input  logic                                    reset,

        input  logic                                    exePacketValid0_i,
        input  wbPkg::exePacket_t                       exePacket0_i,
        output logic                                    writebkValid0_o,
        output wbPkg::ctrlFu_t                          ctrlFU0_o,
        output logic                                    bypassValid0_o,
        output wbPkg::bypassPacket_t                    bypassPacket0_o,

        input  logic                                    exePacketValid1_i,
        input  wbPkg::exePacket_t                       exePacket1_i,
        output logic                                    writebkValid1_o,
        output wbPkg::ctrlFu_t                          ctrlFU1_o,
        output logic                                    bypassValid1_o,
        output wbPkg::bypassPacket_t                    bypassPacket1_o,

        input  logic                                    exePacketValid2_i,
        input  wbPkg::exePacket_t                       exePacket2_i,
        output logic                                    writebkValid2_o,
        output wbPkg::ctrlFu_t                          ctrlFU2_o,
        output logic                                    bypassValid2_o,
        output wbPkg::bypassPacket_t                    bypassPacket2_o,
        output logic [wbPkg::sizePc-1:0]                computedAddr2_o,

        input  logic                                    lsuPacketValid0_i,
        input  wbPkg::lsuPacket_t                       lsuPacket0_i,
        input  wbPkg::ldViolation_t                     ldViolationPacket_i,
        output logic                                    writebkValid3_o,
        output wbPkg::ctrlFu_t                          ctrlFU3_o,
        output logic                                    bypassValid3_o,
        output wbPkg::bypassPacket_t                    bypassPacket3_o,
        output logic                                    agenIqFreedValid0_o,
        output logic [wbPkg::sizeIssueQLog-1:0]         agenIqEntry0_o,
        output wbPkg::ldViolation_t                     ldViolationPacket_o,

        output logic                                    ctrlVerified_o,
        output logic                                    ctrlMispredict_o,
        output logic                                    ctrlConditional_o,
        output logic [wbPkg::checkpointsLog-1:0]        ctrlSMTid_o,
        output logic [wbPkg::sizePc-1:0]                ctrlTargetAddr_o,
        output logic                                    ctrlBrDirection_o,
        output logic [wbPkg::sizeCtiLog-1:0]            ctrlCtiQueueIndex_o
);

        wbLaneIf lane0 ();
        wbLaneIf lane1 ();
        wbLaneIf lane2 ();
        wbLaneIf lane3 ();      // load/store lane.
        squashIf squashBus ();

        logic [wbPkg::sizeIssueQLog-1:0]        lsuIqEntry;
        wbPkg::ldViolation_t                    ldViolation;

        // ============================================================
        // input registers
        // ============================================================
        wbLaneReg lane0Reg (
                .clk(clk), .reset(reset), .valid_i(exePacketValid0_i),
                .branchMask_i(exePacket0_i.branchMask), .flags_i(exePacket0_i.flags),
                .phyDest_i(exePacket0_i.phyDest), .alId_i(exePacket0_i.alId),
                .data_i(exePacket0_i.data), .smtId_i(exePacket0_i.smtId), .lane(lane0)
        );

        wbLaneReg lane1Reg (
                .clk(clk), .reset(reset), .valid_i(exePacketValid1_i),
                .branchMask_i(exePacket1_i.branchMask), .flags_i(exePacket1_i.flags),
                .phyDest_i(exePacket1_i.phyDest), .alId_i(exePacket1_i.alId),
                .data_i(exePacket1_i.data), .smtId_i(exePacket1_i.smtId), .lane(lane1)
        );

        wbLaneReg lane2Reg (
                .clk(clk), .reset(reset), .valid_i(exePacketValid2_i),
                .branchMask_i(exePacket2_i.branchMask), .flags_i(exePacket2_i.flags),
                .phyDest_i(exePacket2_i.phyDest), .alId_i(exePacket2_i.alId),
                .data_i(exePacket2_i.data), .smtId_i(exePacket2_i.smtId), .lane(lane2)
        );

        // load/store results carry no checkpoint id.
        wbLaneReg lane3Reg (
                .clk(clk), .reset(reset), .valid_i(lsuPacketValid0_i),
                .branchMask_i(lsuPacket0_i.branchMask), .flags_i(lsuPacket0_i.flags),
                .phyDest_i(lsuPacket0_i.phyDest), .alId_i(lsuPacket0_i.alId),
                .data_i(lsuPacket0_i.data), .smtId_i('0), .lane(lane3)
        );

        // ============================================================
        // branch resolution and lane formatting
        // ============================================================
        branchResolve branchRes (
                .clk(clk), .reset(reset), .valid_i(exePacketValid2_i), .lane2(lane2),
                .ctiIndex_i(exePacket2_i.ctiIndex), .targetAddr_i(exePacket2_i.targetAddr),
                .brDirection_i(exePacket2_i.brDirection), .squash(squashBus),
                .ctrlVerified_o(ctrlVerified_o), .ctrlMispredict_o(ctrlMispredict_o),
                .ctrlConditional_o(ctrlConditional_o), .ctrlSMTid_o(ctrlSMTid_o),
                .ctrlTargetAddr_o(ctrlTargetAddr_o), .ctrlBrDirection_o(ctrlBrDirection_o),
                .ctrlCtiQueueIndex_o(ctrlCtiQueueIndex_o), .computedAddr_o(computedAddr2_o)
        );

        wbLaneFormat lane0Fmt (
                .lane(lane0), .squash(squashBus), .writebkValid_o(writebkValid0_o),
                .ctrlFu_o(ctrlFU0_o), .bypassValid_o(bypassValid0_o),
                .bypassPacket_o(bypassPacket0_o)
        );

        wbLaneFormat lane1Fmt (
                .lane(lane1), .squash(squashBus), .writebkValid_o(writebkValid1_o),
                .ctrlFu_o(ctrlFU1_o), .bypassValid_o(bypassValid1_o),
                .bypassPacket_o(bypassPacket1_o)
        );

        wbLaneFormat lane2Fmt (
                .lane(lane2), .squash(squashBus), .writebkValid_o(writebkValid2_o),
                .ctrlFu_o(ctrlFU2_o), .bypassValid_o(bypassValid2_o),
                .bypassPacket_o(bypassPacket2_o)
        );

        wbLaneFormat lane3Fmt (
                .lane(lane3), .squash(squashBus), .writebkValid_o(writebkValid3_o),
                .ctrlFu_o(ctrlFU3_o), .bypassValid_o(bypassValid3_o),
                .bypassPacket_o(bypassPacket3_o)
        );

        // ============================================================
        // load/store side
        // ============================================================
        always_ff @(posedge clk)
        begin
                if (lsuPacketValid0_i)
                begin
                        lsuIqEntry <= lsuPacket0_i.iqEntry;
                end
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        ldViolation <= '0;
                end
                else if (lsuPacketValid0_i)
                begin
                        ldViolation <= ldViolationPacket_i;
                end
        end

        assign agenIqFreedValid0_o = lane3.valid;        // entry frees on writeback.
        assign agenIqEntry0_o      = lsuIqEntry;
        assign ldViolationPacket_o = ldViolation;

endmodule

//--- tbClock.sv
// clock and reset generator for the writeback testbench.
`timescale 1ns/1ps

module tbClock (
        output logic clk_o,
        output logic reset_o
);

        localparam int halfPeriodNs = 5;        // 10 ns clock.
        localparam int resetCycles  = 5;

        initial
        begin
                clk_o = 1'b0;
                forever #(halfPeriodNs) clk_o = ~clk_o;
        end

        initial
        begin
                reset_o = 1'b1;
                repeat (resetCycles) @(posedge clk_o);
                reset_o <= 1'b0;                // released after the fifth edge.
        end

endmodule

//--- writeBackTb.sv
// testbench for the writeback stage: random stimulus, reference model, checks and report.
`timescale 1ns/1ps

module writeBackTb;

        // ============================================================
        // run length and test modes
        // ============================================================
        localparam int resetCycles    = 5;
        localparam int cyclesPerTest  = 200;
        localparam int totalCycles    = resetCycles + 1 + 5 * cyclesPerTest;
        localparam int watchdogCycles = totalCycles + 100;
        localparam int modeReset = 0, modeNoMispredict = 1, modeBypass = 2;
        localparam int modeBranch = 3, modeSquash = 4, modeLsu = 5;

        logic clk, reset, lsuValid, agenFreed;
        logic exeValid [3];
        wbPkg::exePacket_t exeIn [3];
        wbPkg::lsuPacket_t lsuIn;
        wbPkg::ldViolation_t ldvIn, ldvOut;
        logic wbValid [4];
        logic bpValid [4];
        wbPkg::ctrlFu_t ctrlFu [4];
        wbPkg::bypassPacket_t bpPacket [4];
        logic [wbPkg::sizeIssueQLog-1:0] agenEntry;
        logic ctrlVerified, ctrlMispredict, ctrlConditional, ctrlBrDirection;
        logic [wbPkg::checkpointsLog-1:0] ctrlSmtId;
        logic [wbPkg::sizePc-1:0] ctrlTarget, computedAddr;
        logic [wbPkg::sizeCtiLog-1:0] ctrlCti;

        // reference model state, one entry per lane.
        logic mValid [4];
        logic mKnown [4];                       // lane fields loaded at least once.
        logic [wbPkg::checkpoints-1:0] mMask [4];
        logic [wbPkg::executionFlags-1:0] mFlags [4];
        logic [wbPkg::sizePhysicalLog-1:0] mPhy [4];
        logic [wbPkg::sizeActiveListLog-1:0] mAl [4];
        logic [wbPkg::sizeData-1:0] mData [4];
        logic [wbPkg::checkpointsLog-1:0] mSmt [4];
        logic [wbPkg::sizeCtiLog-1:0] mCti;
        logic [wbPkg::sizePc-1:0] mTarget;
        logic mDir, mIqKnown;
        logic [wbPkg::sizeIssueQLog-1:0] mIq;
        wbPkg::ldViolation_t mLdv;

        logic [31:0] rngState;
        int testMode, errorCount, checkCount, testsPassed, testsFailed;

        tbClock clockGen (.clk_o(clk), .reset_o(reset));

        writeBack writeBack_inst (
                .clk(clk), .reset(reset),
                .exePacketValid0_i(exeValid[0]), .exePacket0_i(exeIn[0]),
                .writebkValid0_o(wbValid[0]), .ctrlFU0_o(ctrlFu[0]),
                .bypassValid0_o(bpValid[0]), .bypassPacket0_o(bpPacket[0]),
                .exePacketValid1_i(exeValid[1]), .exePacket1_i(exeIn[1]),
                .writebkValid1_o(wbValid[1]), .ctrlFU1_o(ctrlFu[1]),
                .bypassValid1_o(bpValid[1]), .bypassPacket1_o(bpPacket[1]),
                .exePacketValid2_i(exeValid[2]), .exePacket2_i(exeIn[2]),
                .writebkValid2_o(wbValid[2]), .ctrlFU2_o(ctrlFu[2]),
                .bypassValid2_o(bpValid[2]), .bypassPacket2_o(bpPacket[2]),
                .computedAddr2_o(computedAddr),
                .lsuPacketValid0_i(lsuValid), .lsuPacket0_i(lsuIn), .ldViolationPacket_i(ldvIn),
                .writebkValid3_o(wbValid[3]), .ctrlFU3_o(ctrlFu[3]),
                .bypassValid3_o(bpValid[3]), .bypassPacket3_o(bpPacket[3]),
                .agenIqFreedValid0_o(agenFreed), .agenIqEntry0_o(agenEntry),
                .ldViolationPacket_o(ldvOut),
                .ctrlVerified_o(ctrlVerified), .ctrlMispredict_o(ctrlMispredict),
                .ctrlConditional_o(ctrlConditional), .ctrlSMTid_o(ctrlSmtId),
                .ctrlTargetAddr_o(ctrlTarget), .ctrlBrDirection_o(ctrlBrDirection),
                .ctrlCtiQueueIndex_o(ctrlCti)
        );

        function automatic logic [31:0] xorshift32(input logic [31:0] s);
                logic [31:0] x;
                x = s ^ (s << 13);
                x = x ^ (x >> 17);
                return x ^ (x << 5);
        endfunction

        task automatic randomWide(output logic [159:0] bits);
                int i;
                for (i = 0; i < 5; i++)
                begin
                        rngState = xorshift32(rngState);
                        bits[i*32 +: 32] = rngState;
                end
        endtask

        task automatic checkField(input string name, input logic [63:0] actual,
                                  input logic [63:0] expected);
                checkCount++;
                assert (actual === expected)
                else
                begin
                        $display("mismatch %s: expected %h, actual %h", name, expected, actual);
                        errorCount++;
                end
        endtask

        // ============================================================
        // output checks against the model
        // ============================================================
        task automatic checkOutputs();
                logic squashValid, hit;
                wbPkg::ctrlFu_t expCtrl;
                wbPkg::bypassPacket_t expBypass;
                int l;
                squashValid = mValid[2] & mFlags[2][wbPkg::flagMispredict];
                for (l = 0; l < 4; l++)
                begin
                        hit = squashValid & mMask[l][mSmt[2]];  // depends on the bad checkpoint.
                        checkField($sformatf("writebkValid%0d_o", l), 64'(wbValid[l]),
                                   64'(mValid[l] & ~hit));
                        checkField($sformatf("bypassValid%0d_o", l), 64'(bpValid[l]),
                                   64'(mValid[l] & mFlags[l][wbPkg::flagDestValid]));
                        if (mKnown[l])
                        begin
                                expCtrl.alId = mAl[l];
                                expCtrl.flags = mFlags[l][wbPkg::writebackFlags-1:0];
                                expBypass.phyDest = mPhy[l];
                                expBypass.data = mData[l];
                                expBypass.smtId = mSmt[l];
                                checkField($sformatf("ctrlFU%0d_o", l), 64'(ctrlFu[l]), 64'(expCtrl));
                                checkField($sformatf("bypassPacket%0d_o", l), 64'(bpPacket[l]),
                                           64'(expBypass));
                        end
                end
                checkField("ctrlVerified_o", 64'(ctrlVerified), 64'(mValid[2]));
                if (mKnown[2])
                begin
                        checkField("ctrlMispredict_o", 64'(ctrlMispredict),
                                   64'(mFlags[2][wbPkg::flagMispredict]));
                        checkField("ctrlConditional_o", 64'(ctrlConditional),
                                   64'(mFlags[2][wbPkg::flagConditional]));
                        checkField("ctrlSMTid_o", 64'(ctrlSmtId), 64'(mSmt[2]));
                end
                checkField("ctrlTargetAddr_o", 64'(ctrlTarget), 64'(mTarget));
                checkField("ctrlBrDirection_o", 64'(ctrlBrDirection), 64'(mDir));
                checkField("ctrlCtiQueueIndex_o", 64'(ctrlCti), 64'(mCti));
                checkField("computedAddr2_o", 64'(computedAddr), 64'(mTarget));
                checkField("agenIqFreedValid0_o", 64'(agenFreed), 64'(mValid[3]));
                if (mIqKnown)
                begin
                        checkField("agenIqEntry0_o", 64'(agenEntry), 64'(mIq));
                end
                checkField("ldViolationPacket_o", 64'(ldvOut), 64'(mLdv));
        endtask

        task automatic driveInputs();
                logic [159:0] bits;
                int n;
                for (n = 0; n < 3; n++)
                begin
                        randomWide(bits);
                        exeIn[n] = bits[$bits(wbPkg::exePacket_t)-1:0];
                        exeValid[n] = bits[159 - n];
                end
                randomWide(bits);
                lsuIn = bits[$bits(wbPkg::lsuPacket_t)-1:0];
                ldvIn = bits[$bits(wbPkg::lsuPacket_t) +: $bits(wbPkg::ldViolation_t)];
                lsuValid = bits[159];
                case (testMode)
                        modeReset:
                        begin
                                if (!reset)
                                begin
                                        exeValid = '{1'b0, 1'b0, 1'b0};  // idle right after reset.
                                        lsuValid = 1'b0;
                                end
                        end
                        modeNoMispredict: exeIn[2].flags[wbPkg::flagMispredict] = 1'b0;
                        modeSquash:
                        begin
                                exeValid = '{1'b1, 1'b1, 1'b1};
                                lsuValid = 1'b1;
                                exeIn[2].flags[wbPkg::flagMispredict] = 1'b1;
                        end
                        default: ;
                endcase
        endtask

        // state after the coming rising edge.
        task automatic advanceModel(input logic resetNow);
                int l;
                for (l = 0; l < 3; l++)
                begin
                        if (exeValid[l])
                        begin
                                mMask[l] = exeIn[l].branchMask;
                                mFlags[l] = exeIn[l].flags;
                                mPhy[l] = exeIn[l].phyDest;
                                mAl[l] = exeIn[l].alId;
                                mData[l] = exeIn[l].data;
                                mSmt[l] = exeIn[l].smtId;
                                mKnown[l] = 1'b1;
                        end
                        mValid[l] = ~resetNow & exeValid[l];
                end
                if (lsuValid)
                begin
                        mMask[3] = lsuIn.branchMask;
                        mFlags[3] = lsuIn.flags;
                        mPhy[3] = lsuIn.phyDest;
                        mAl[3] = lsuIn.alId;
                        mData[3] = lsuIn.data;
                        mSmt[3] = '0;                   // no checkpoint id on the load/store lane.
                        mKnown[3] = 1'b1;
                        mIq = lsuIn.iqEntry;
                        mIqKnown = 1'b1;
                end
                mValid[3] = ~resetNow & lsuValid;
                if (resetNow)
                begin
                        mCti = '0;
                        mTarget = '0;
                        mDir = 1'b0;
                        mLdv = '0;
                end
                else
                begin
                        if (exeValid[2])
                        begin
                                mCti = exeIn[2].ctiIndex;
                                mTarget = exeIn[2].targetAddr;
                                mDir = exeIn[2].brDirection;
                        end
                        if (lsuValid)
                        begin
                                mLdv = ldvIn;
                        end
                end
        endtask

        task automatic runStep();
                @(negedge clk);
                checkOutputs();
                driveInputs();
                advanceModel(reset);
        endtask

        task automatic runTest(input string name, input int mode, input int cycles);
                int errorsBefore;
                errorsBefore = errorCount;
                testMode = mode;
                repeat (cycles) runStep();
                if (errorCount == errorsBefore)
                begin
                        testsPassed++;
                        $display("test %s: passed", name);
                end
                else
                begin
                        testsFailed++;
                        $display("test %s: failed with %0d errors", name, errorCount - errorsBefore);
                end
        endtask

        // ============================================================
        // main sequence
        // ============================================================
        initial
        begin
                rngState = 32'd24078;
                {errorCount, checkCount, testsPassed, testsFailed, testMode} = '0;
                exeValid = '{1'b0, 1'b0, 1'b0};
                exeIn = '{'0, '0, '0};
                lsuValid = 1'b0;
                lsuIn = '0;
                ldvIn = '0;
                mValid = '{1'b0, 1'b0, 1'b0, 1'b0};
                mKnown = '{1'b0, 1'b0, 1'b0, 1'b0};
                {mCti, mTarget, mDir, mIq, mIqKnown, mLdv} = '0;
                runTest("reset", modeReset, resetCycles + 1);
                runTest("writeback without mispredict", modeNoMispredict, cyclesPerTest);
                runTest("bypass", modeBypass, cyclesPerTest);
                runTest("branch control", modeBranch, cyclesPerTest);
                runTest("squash", modeSquash, cyclesPerTest);
                runTest("load/store side", modeLsu, cyclesPerTest);
                $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                         testsPassed, testsFailed, checkCount, errorCount);
                if (testsFailed == 0 && errorCount == 0)
                        $display("STATUS: PASS");
                else
                        $display("STATUS: FAIL");
                $finish;
        end

        initial
        begin
                #(watchdogCycles * 10);
                $display("watchdog expired: tests did not finish within %0d cycles", watchdogCycles);
                $display("STATUS: FAIL");
                $finish;
        end

endmodule

//--- filelist.f
wbPkg.sv
wbLaneIf.sv
wbLaneReg.sv
branchResolve.sv
wbLaneFormat.sv
writeBack.sv
tbClock.sv
writeBackTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the writeback testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module writeBackTb -o writeBackSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/writeBackSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
echo "pass message not found"
exit 1
